/* Bender.yml */
package:
  name: cache

sources:
  # packages first, the rest of the design depends on them
  - verilog/cache_cfg_pkg.sv
  - verilog/cache_bus_pkg.sv
  - verilog/cache_ctrl.sv
  - verilog/cache_tag_array.sv
  - verilog/cache_data_array.sv
  - verilog/cache_wt_buffer.sv
  - verilog/cache_top.sv

  - target: test
    files:
      - bench/cache_be_mem.sv
      - bench/cache_tb.sv

/* bench/cache_be_mem.sv */
module cache_be_mem
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_i,
   // testbench holds back write accepts while high
   input  logic       withhold_wr_i,
   // read channel
   input  logic       rd_req_i,
   input  line_addr_t rd_addr_i,
   output logic       rd_valid_o,
   output offset_t    rd_beat_o,
   output data_t      rd_data_o,
   output logic       rd_busy_o,
   // write channel
   input  logic       wr_req_i,
   input  word_addr_t wr_addr_i,
   input  data_t      wr_data_i,
   input  strb_t      wr_strb_i,
   output logic       wr_ack_o
);

   // contents and delays are loaded by the testbench
   data_t mem [2 ** $bits(word_addr_t)];
   int    ack_delay [256];

   // cache outputs sampled mid-cycle
   logic       arst_s;
   logic       rd_req_s;
   line_addr_t rd_addr_s;
   logic       wr_req_s;
   word_addr_t wr_addr_s;
   data_t      wr_data_s;
   strb_t      wr_strb_s;
   logic       hold_s;

   line_addr_t fill_line;
   int         beat_cnt;
   int         wait_cnt;
   int         wr_count;

   initial begin
      rd_valid_o = 1'b0;
      rd_beat_o  = '0;
      rd_data_o  = '0;
      rd_busy_o  = 1'b0;
      wr_ack_o   = 1'b0;
      arst_s     = 1'b1;
      rd_req_s   = 1'b0;
      wr_req_s   = 1'b0;
      hold_s     = 1'b0;
      fill_line  = '0;
      beat_cnt   = 0;
      wait_cnt   = 0;
      wr_count   = 0;
   end

   always @(negedge clk_i) begin
      arst_s    = arst_i;
      rd_req_s  = rd_req_i;
      rd_addr_s = rd_addr_i;
      wr_req_s  = wr_req_i;
      wr_addr_s = wr_addr_i;
      wr_data_s = wr_data_i;
      wr_strb_s = wr_strb_i;
      hold_s    = withhold_wr_i;
   end

   always @(posedge clk_i) begin
      #1;
      if (arst_s) begin
         rd_busy_o  = 1'b0;
         rd_valid_o = 1'b0;
         wr_ack_o   = 1'b0;
         wait_cnt   = 0;
      end else begin
         ////////////////////
         // line fill, one beat per cycle
         ////////////////////
         if (rd_busy_o) begin
            if (beat_cnt < NWORDS) begin
               rd_valid_o = 1'b1;
               rd_beat_o  = offset_t'(beat_cnt);
               rd_data_o  = mem[{fill_line, offset_t'(beat_cnt)}];
               beat_cnt++;
            end else begin
               rd_valid_o = 1'b0;
               rd_busy_o  = 1'b0;
            end
         end else if (rd_req_s) begin
            rd_busy_o = 1'b1;
            fill_line = rd_addr_s;
            beat_cnt  = 0;
         end

         ////////////////////
         // write accept
         ////////////////////
         // the sample taken during an accept shows the popped entry
         if (wr_ack_o) begin
            wr_ack_o = 1'b0;
         end else if (wr_req_s && !hold_s) begin
            if (wait_cnt < ack_delay[wr_count % 256]) begin
               wait_cnt++;
            end else begin
               for (int b = 0; b < NBYTES; b++) begin
                  if (wr_strb_s[b]) begin
                     mem[wr_addr_s][8*b +: 8] = wr_data_s[8*b +: 8];
                  end
               end
               wr_ack_o = 1'b1;
               wait_cnt = 0;
               wr_count++;
            end
         end
      end
   end

endmodule

/* bench/cache_tb.sv */
module cache_tb
   import cache_cfg_pkg::*, cache_bus_pkg::*;
();

   localparam int RESET_CYCLES    = 5;
   localparam int CYCLES_PER_STEP = 40;
   localparam int MEM_WORDS       = 2 ** $bits(word_addr_t);

   typedef enum logic [2:0] {
      OP_READ,
      OP_WRITE,
      OP_INVAL,
      OP_HOLD,
      OP_STALL_WRITE,
      OP_DRAIN
   } op_e;

   typedef struct {
      op_e        op;
      word_addr_t addr;
      data_t      wdata;
      strb_t      strb;
      logic       hit;
      data_t      exp;
   } step_t;

   logic       clk;
   logic       arst;
   logic       req;
   word_addr_t addr;
   data_t      wdata;
   strb_t      wstrb;
   logic       invalidate;
   logic       ack;
   data_t      rdata;
   logic       rd_req;
   line_addr_t rd_addr;
   logic       rd_valid;
   offset_t    rd_beat;
   data_t      rd_data;
   logic       rd_busy;
   logic       wr_req;
   word_addr_t wr_addr;
   data_t      wr_data;
   strb_t      wr_strb;
   logic       wr_ack;
   logic       wtbuf_full;
   logic       wtbuf_empty;
   logic       write_hit;
   logic       write_miss;
   logic       read_hit;
   logic       read_miss;
   logic       withhold_wr;

   step_t        steps [$];
   logic         steps_ready = 1'b0;
   data_t        shadow [MEM_WORDS];
   // writes acknowledged to the host, not yet seen on the back end
   wtbuf_entry_t exp_wr [$];

   cache_top uut (
      .clk_i         (clk),
      .arst_i        (arst),
      .req_i         (req),
      .addr_i        (addr),
      .wdata_i       (wdata),
      .wstrb_i       (wstrb),
      .ack_o         (ack),
      .rdata_o       (rdata),
      .invalidate_i  (invalidate),
      .rd_req_o      (rd_req),
      .rd_addr_o     (rd_addr),
      .rd_valid_i    (rd_valid),
      .rd_beat_i     (rd_beat),
      .rd_data_i     (rd_data),
      .rd_busy_i     (rd_busy),
      .wr_req_o      (wr_req),
      .wr_addr_o     (wr_addr),
      .wr_data_o     (wr_data),
      .wr_strb_o     (wr_strb),
      .wr_ack_i      (wr_ack),
      .wtbuf_full_o  (wtbuf_full),
      .wtbuf_empty_o (wtbuf_empty),
      .write_hit_o   (write_hit),
      .write_miss_o  (write_miss),
      .read_hit_o    (read_hit),
      .read_miss_o   (read_miss)
   );

   cache_be_mem u_be_mem (
      .clk_i         (clk),
      .arst_i        (arst),
      .withhold_wr_i (withhold_wr),
      .rd_req_i      (rd_req),
      .rd_addr_i     (rd_addr),
      .rd_valid_o    (rd_valid),
      .rd_beat_o     (rd_beat),
      .rd_data_o     (rd_data),
      .rd_busy_o     (rd_busy),
      .wr_req_i      (wr_req),
      .wr_addr_i     (wr_addr),
      .wr_data_i     (wr_data),
      .wr_strb_i     (wr_strb),
      .wr_ack_o      (wr_ack)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("error: %0t: %s, got %h, expected %h", $time, what, got, exp);
         $display("Result: FAILED");
         $fatal(1, "check failed");
      end
   endtask

   ////////////////////
   // stimulus table
   ////////////////////

   // reads take the expected word from the shadow, writes merge into it
   task automatic add_access(input op_e op, input tag_t tag, input index_t index,
                             input offset_t offset, input data_t wd,
                             input strb_t ws, input logic hit);
      step_t s;
      s.op    = op;
      s.addr  = {tag, index, offset};
      s.wdata = wd;
      s.strb  = ws;
      s.hit   = hit;
      s.exp   = '0;
      if (op == OP_READ) begin
         s.exp = shadow[s.addr];
      end else begin
         for (int b = 0; b < NBYTES; b++) begin
            if (ws[b]) begin
               shadow[s.addr][8*b +: 8] = wd[8*b +: 8];
            end
         end
      end
      steps.push_back(s);
   endtask

   task automatic add_ctrl(input op_e op);
      step_t s;
      s.op    = op;
      s.addr  = '0;
      s.wdata = '0;
      s.strb  = '0;
      s.hit   = 1'b0;
      s.exp   = '0;
      steps.push_back(s);
   endtask

   task automatic build_steps();
      // first access to a line misses, the rest of the line hits
      add_access(OP_READ, 8'h01, 4'h0, 2'd0, '0, '0, 1'b0);
      add_access(OP_READ, 8'h01, 4'h0, 2'd1, '0, '0, 1'b1);
      add_access(OP_READ, 8'h01, 4'h0, 2'd3, '0, '0, 1'b1);
      // write hits and a write miss that allocates nothing
      add_access(OP_WRITE, 8'h01, 4'h0, 2'd2, 32'h1234_5678, 4'b1111, 1'b1);
      add_access(OP_WRITE, 8'h07, 4'h9, 2'd1, 32'hcafe_0001, 4'b1111, 1'b0);
      add_access(OP_WRITE, 8'h01, 4'h0, 2'd0, 32'haabb_ccdd, 4'b0110, 1'b1);
      add_access(OP_READ, 8'h01, 4'h0, 2'd2, '0, '0, 1'b1);
      add_access(OP_READ, 8'h01, 4'h0, 2'd0, '0, '0, 1'b1);
      // partial write then at once a read of the same word
      add_access(OP_WRITE, 8'h01, 4'h0, 2'd1, 32'h0000_beef, 4'b0011, 1'b1);
      add_access(OP_READ, 8'h01, 4'h0, 2'd1, '0, '0, 1'b1);
      add_access(OP_WRITE, 8'h01, 4'h0, 2'd1, 32'h5a00_0000, 4'b1000, 1'b1);
      add_access(OP_READ, 8'h01, 4'h0, 2'd1, '0, '0, 1'b1);
      add_access(OP_READ, 8'h07, 4'h9, 2'd1, '0, '0, 1'b0);
      // set 5 with A, B, A, C keeps A and C
      add_access(OP_READ, 8'h02, 4'h5, 2'd0, '0, '0, 1'b0);
      add_access(OP_READ, 8'h03, 4'h5, 2'd1, '0, '0, 1'b0);
      add_access(OP_READ, 8'h02, 4'h5, 2'd2, '0, '0, 1'b1);
      add_access(OP_READ, 8'h04, 4'h5, 2'd3, '0, '0, 1'b0);
      add_access(OP_READ, 8'h02, 4'h5, 2'd0, '0, '0, 1'b1);
      add_access(OP_READ, 8'h03, 4'h5, 2'd1, '0, '0, 1'b0);
      add_ctrl(OP_INVAL);
      add_access(OP_READ, 8'h01, 4'h0, 2'd0, '0, '0, 1'b0);
      add_access(OP_READ, 8'h01, 4'h0, 2'd3, '0, '0, 1'b1);
      add_access(OP_READ, 8'h02, 4'h5, 2'd0, '0, '0, 1'b0);
      // back end stops accepting, four writes fill the buffer
      add_ctrl(OP_HOLD);
      add_access(OP_WRITE, 8'h01, 4'h0, 2'd0, 32'h0102_0304, 4'b1111, 1'b1);
      add_access(OP_WRITE, 8'h01, 4'h0, 2'd1, 32'h1111_2222, 4'b0101, 1'b1);
      add_access(OP_WRITE, 8'h06, 4'hc, 2'd2, 32'h3333_4444, 4'b1100, 1'b0);
      add_access(OP_WRITE, 8'h06, 4'hc, 2'd3, 32'h5555_6666, 4'b0001, 1'b0);
      add_access(OP_STALL_WRITE, 8'h01, 4'h0, 2'd2, 32'h7777_8888, 4'b1111, 1'b1);
      add_ctrl(OP_DRAIN);
      add_access(OP_READ, 8'h01, 4'h0, 2'd2, '0, '0, 1'b1);
      add_access(OP_READ, 8'h06, 4'hc, 2'd2, '0, '0, 1'b0);
   endtask

   ////////////////////
   // step execution
   ////////////////////

   task automatic wait_drained();
      @(negedge clk);
      while (!wtbuf_empty) begin
         @(negedge clk);
      end
   endtask

   task automatic check_idle();
      check_value("ack after reset", ack, 0);
      check_value("rd_req after reset", rd_req, 0);
      check_value("wr_req after reset", wr_req, 0);
      check_value("strobes after reset", {write_hit, write_miss, read_hit, read_miss}, 0);
      check_value("buffer empty after reset", wtbuf_empty, 1);
      check_value("buffer full after reset", wtbuf_full, 0);
   endtask

   task automatic run_step(input step_t s);
      logic saw_miss;
      saw_miss = 1'b0;
      @(posedge clk);
      #1;
      case (s.op)
         OP_INVAL: begin
            req        = 1'b0;
            invalidate = 1'b1;
            @(posedge clk);
            #1;
            invalidate = 1'b0;
         end
         OP_HOLD: begin
            req = 1'b0;
            wait_drained();
            @(posedge clk);
            #1;
            withhold_wr = 1'b1;
         end
         OP_DRAIN: begin
            req = 1'b0;
            wait_drained();
            check_value("buffer full after drain", wtbuf_full, 0);
         end
         default: begin
            req   = 1'b1;
            addr  = s.addr;
            wdata = s.wdata;
            wstrb = s.strb;
            if (s.op == OP_STALL_WRITE) begin
               // no write may be taken while nothing leaves the buffer
               for (int i = 0; i < 8; i++) begin
                  @(negedge clk);
                  check_value("buffer full before fifth write", wtbuf_full, 1);
                  check_value("ack while buffer full", ack, 0);
               end
               @(posedge clk);
               #1;
               withhold_wr = 1'b0;
            end
            @(negedge clk);
            while (!ack) begin
               if (read_miss) begin
                  saw_miss = 1'b1;
               end
               @(negedge clk);
            end
            if (s.op == OP_READ) begin
               check_value($sformatf("read data at %h", s.addr), rdata, s.exp);
               // a read is always answered from the cache, after a fill too
               check_value($sformatf("read hit at %h", s.addr), read_hit, 1);
               check_value($sformatf("read miss at %h", s.addr), saw_miss, !s.hit);
            end else begin
               check_value($sformatf("write hit at %h", s.addr), write_hit, s.hit);
               check_value($sformatf("write miss at %h", s.addr), write_miss, !s.hit);
               exp_wr.push_back('{addr: s.addr, data: s.wdata, strb: s.strb});
            end
         end
      endcase
   endtask

   // back-end writes must come out in issue order
   always @(negedge clk) begin
      if (!arst && wr_ack) begin
         check_value("wr_req during accept", wr_req, 1);
         check_value("write accepted with none pending", exp_wr.size() != 0, 1);
         check_value("write address", wr_addr, exp_wr[0].addr);
         check_value("write data", wr_data, exp_wr[0].data);
         check_value("write strobe", wr_strb, exp_wr[0].strb);
         exp_wr.delete(0);
      end
   end

   initial begin
      int limit;
      wait (steps_ready);
      limit = RESET_CYCLES + CYCLES_PER_STEP * steps.size();
      repeat (limit) @(posedge clk);
      $display("timeout: the cache stopped responding, no result after %0d cycles", limit);
      $display("Result: FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      data_t word;
      req         = 1'b0;
      addr        = '0;
      wdata       = '0;
      wstrb       = '0;
      invalidate  = 1'b0;
      withhold_wr = 1'b0;
      arst        = 1'b1;

      void'($urandom(86));
      for (int a = 0; a < MEM_WORDS; a++) begin
         word = $urandom;
         u_be_mem.mem[a] = word;
         shadow[a] = word;
      end
      for (int k = 0; k < 256; k++) begin
         u_be_mem.ack_delay[k] = $urandom_range(3, 0);
      end
      build_steps();
      steps_ready = 1'b1;

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst = 1'b0;
      @(negedge clk);
      check_idle();

      foreach (steps[i]) begin
         run_step(steps[i]);
      end

      @(posedge clk);
      #1;
      req = 1'b0;
      wait_drained();
      check_value("writes never accepted", exp_wr.size(), 0);
      for (int a = 0; a < MEM_WORDS; a++) begin
         check_value($sformatf("memory word %h", a), u_be_mem.mem[a], shadow[a]);
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

/* tb.f */
verilog/cache_cfg_pkg.sv
verilog/cache_bus_pkg.sv
verilog/cache_ctrl.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/cache_wt_buffer.sv
verilog/cache_top.sv
bench/cache_be_mem.sv
bench/cache_tb.sv

/* verilog/cache_bus_pkg.sv */
package cache_bus_pkg;
   import cache_cfg_pkg::*;

   // word address, byte bits dropped
   typedef logic [ADDR_W-NBYTES_W-1:0] word_addr_t;

   // line address for the fill request
   typedef logic [ADDR_W-NBYTES_W-WORD_OFFSET_W-1:0] line_addr_t;

   // fields of a word address, msb to lsb
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [NLINES_W-1:0] index_t;
   typedef logic [WORD_OFFSET_W-1:0] offset_t;

   // one bit per way, one-hot on a hit
   typedef logic [NWAYS-1:0] way_t;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [NBYTES-1:0] strb_t;

   // one write waiting for the back end
   typedef struct packed {
      word_addr_t addr;
      data_t      data;
      strb_t      strb;
   } wtbuf_entry_t;

endpackage

/* verilog/cache_cfg_pkg.sv */
package cache_cfg_pkg;

   ////////////////////
   // cache geometry
   ////////////////////

   // the replacement state is one lru bit, so two ways
   localparam int NWAYS = 2;

   localparam int NLINES_W = 4;
   localparam int NLINES = 2 ** NLINES_W;

   // words per line
   localparam int WORD_OFFSET_W = 2;
   localparam int NWORDS = 2 ** WORD_OFFSET_W;

   ////////////////////
   // words and addresses
   ////////////////////

   // front-end and back-end share the word width
   localparam int DATA_W = 32;
   localparam int NBYTES = DATA_W / 8;
   localparam int NBYTES_W = $clog2(NBYTES);

   // byte address
   localparam int ADDR_W = 16;

   // whatever is left above index and offset
   localparam int TAG_W = ADDR_W - (NBYTES_W + WORD_OFFSET_W + NLINES_W);

   ////////////////////
   // write-through buffer
   ////////////////////

   localparam int WTBUF_DEPTH_W = 2;
   localparam int WTBUF_DEPTH = 2 ** WTBUF_DEPTH_W;

endpackage

/* verilog/cache_ctrl.sv */
module cache_ctrl
   import cache_bus_pkg::*;
(
   input  logic    clk_i,
   input  logic    arst_i,
   // registered front-end request
   input  logic    req_q_i,
   input  strb_t   wstrb_q_i,
   input  offset_t offset_q_i,
   input  way_t    way_hit_i,
   input  logic    rd_busy_i,
   // buffer status and back-end write accept
   input  logic    buf_full_i,
   input  logic    buf_empty_i,
   input  logic    wr_ack_i,
   output logic    ack_o,
   output logic    fill_o,
   output logic    buf_push_o,
   output logic    wr_en_o,
   output logic    rd_req_o,
   output logic    write_hit_o,
   output logic    write_miss_o,
   output logic    read_hit_o,
   output logic    read_miss_o
);

   logic    read_access;
   logic    write_access;
   logic    fill_run;
   logic    way_match;
   logic    raw;
   logic    read_hit;
   logic    write_ok;
   logic    fill_pend_q;
   logic    fill_done_q;
   logic    hz_q;
   way_t    hz_way_q;
   offset_t hz_offset_q;

   // zero strobe means read
   assign read_access  = req_q_i & ~(|wstrb_q_i);
   assign write_access = req_q_i & (|wstrb_q_i);

   ////////////////////
   // line fill
   ////////////////////

   // busy from the cycle after the request, so pending covers the gap
   assign fill_o   = fill_pend_q & ~rd_busy_i;
   // one more cycle for the arrays to read back the new line
   assign fill_run = fill_pend_q | fill_done_q | rd_busy_i;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         fill_pend_q <= 1'b0;
         fill_done_q <= 1'b0;
      end else begin
         if (rd_req_o) begin
            fill_pend_q <= 1'b1;
         end else if (fill_o) begin
            fill_pend_q <= 1'b0;
         end
         fill_done_q <= fill_o;
      end
   end

   ////////////////////
   // read-after-write hazard
   ////////////////////

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         hz_q <= 1'b0;
      end else begin
         hz_q <= wr_en_o;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en_o) begin
         hz_way_q    <= way_hit_i;
         hz_offset_q <= offset_q_i;
      end
   end

   assign raw = hz_q & (hz_way_q == way_hit_i) & (hz_offset_q == offset_q_i);

   ////////////////////
   // hit and acknowledge
   ////////////////////

   assign way_match = (|way_hit_i) & ~fill_run;
   assign read_hit  = read_access & way_match & ~raw;
   // full buffer still takes a write when its head leaves on the same edge
   assign write_ok  = write_access & (~buf_full_i | wr_ack_i);

   assign ack_o      = read_hit | write_ok;
   assign buf_push_o = write_ok;
   assign wr_en_o    = write_ok & way_match;

   // miss goes out only once every buffered write has reached memory
   assign rd_req_o = read_access & ~(|way_hit_i) & ~fill_run & buf_empty_i;

   assign write_hit_o  = wr_en_o;
   assign write_miss_o = write_ok & ~way_match;
   assign read_hit_o   = read_hit;
   assign read_miss_o  = rd_req_o;

   // back end takes over the line in the cycle after the request
   a_fill_busy: assert property (@(posedge clk_i) disable iff (arst_i)
      rd_req_o |=> rd_busy_i);

endmodule

/* verilog/cache_data_array.sv */
module cache_data_array
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic    clk_i,
   input  index_t  index_i,
   input  index_t  index_q_i,
   input  offset_t offset_q_i,
   input  way_t    way_hit_i,
   input  way_t    victim_i,
   // write hit from the front end
   input  logic    wr_en_i,
   input  strb_t   wstrb_q_i,
   input  data_t   wdata_q_i,
   // line fill beats
   input  logic    rd_busy_i,
   input  logic    rd_valid_i,
   input  offset_t rd_beat_i,
   input  data_t   rd_data_i,
   output data_t   rdata_o
);

   data_t mem [NWAYS][NLINES][NWORDS];

   // every word of every way at the live index
   data_t line_q [NWAYS][NWORDS];

   logic fill_beat;

   assign fill_beat = rd_busy_i & rd_valid_i;

   ////////////////////
   // writes
   ////////////////////

   always_ff @(posedge clk_i) begin
      for (int w = 0; w < NWAYS; w++) begin
         if (fill_beat) begin
            if (victim_i[w]) begin
               mem[w][index_q_i][rd_beat_i] <= rd_data_i;
            end
         end else if (wr_en_i && way_hit_i[w]) begin
            // byte merge
            for (int b = 0; b < NBYTES; b++) begin
               if (wstrb_q_i[b]) begin
                  mem[w][index_q_i][offset_q_i][8*b +: 8] <= wdata_q_i[8*b +: 8];
               end
            end
         end
      end
   end

   ////////////////////
   // reads
   ////////////////////

   always_ff @(posedge clk_i) begin
      for (int w = 0; w < NWAYS; w++) begin
         for (int k = 0; k < NWORDS; k++) begin
            line_q[w][k] <= mem[w][index_i][k];
         end
      end
   end

   // way_hit is one-hot, or zero on a miss
   always_comb begin
      rdata_o = '0;
      for (int w = 0; w < NWAYS; w++) begin
         if (way_hit_i[w]) begin
            rdata_o = rdata_o | line_q[w][offset_q_i];
         end
      end
   end

endmodule

/* verilog/cache_tag_array.sv */
module cache_tag_array
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic   clk_i,
   input  logic   arst_i,
   input  logic   invalidate_i,
   // live index reads, registered index writes
   input  index_t index_i,
   input  index_t index_q_i,
   input  tag_t   tag_q_i,
   input  logic   fill_i,
   input  logic   touch_i,
   output way_t   way_hit_o,
   output way_t   victim_o
);

   logic [NWAYS-1:0][NLINES-1:0] valid_q;
   // most recently used way per set
   logic [NLINES-1:0]            lru_q;
   tag_t                         tag_mem [NWAYS][NLINES];

   // read stage
   way_t valid_rd_q;
   tag_t tag_rd_q [NWAYS];
   logic lru_rd_q;

   logic vic_idx;
   logic hit_idx;

   // two ways, so the victim is simply the other one
   assign vic_idx  = ~lru_rd_q;
   assign victim_o = way_t'(1) << vic_idx;
   assign hit_idx  = way_hit_o[1];

   always_comb begin
      for (int w = 0; w < NWAYS; w++) begin
         way_hit_o[w] = valid_rd_q[w] & (tag_rd_q[w] == tag_q_i);
      end
   end

   ////////////////////
   // valid and lru
   ////////////////////

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
         lru_q   <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
         lru_q   <= '0;
      end else if (fill_i) begin
         valid_q[vic_idx][index_q_i] <= 1'b1;
         lru_q[index_q_i]            <= vic_idx;
      end else if (touch_i) begin
         lru_q[index_q_i] <= hit_idx;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         tag_mem[vic_idx][index_q_i] <= tag_q_i;
      end
   end

   ////////////////////
   // read stage
   ////////////////////

   // invalidate also drops the word already read out
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_rd_q <= '0;
         lru_rd_q   <= 1'b0;
      end else if (invalidate_i) begin
         valid_rd_q <= '0;
         lru_rd_q   <= 1'b0;
      end else begin
         for (int w = 0; w < NWAYS; w++) begin
            valid_rd_q[w] <= valid_q[w][index_i];
         end
         lru_rd_q <= lru_q[index_i];
      end
   end

   always_ff @(posedge clk_i) begin
      for (int w = 0; w < NWAYS; w++) begin
         tag_rd_q[w] <= tag_mem[w][index_i];
      end
   end

   // fills only go to a way that missed, so no tag is held twice
   a_hit_onehot: assert property (@(posedge clk_i) disable iff (arst_i)
      $onehot0(way_hit_o));

endmodule

/* verilog/cache_top.sv */
module cache_top
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_i,
   // front end
   input  logic       req_i,
   input  word_addr_t addr_i,
   input  data_t      wdata_i,
   input  strb_t      wstrb_i,
   output logic       ack_o,
   output data_t      rdata_o,
   input  logic       invalidate_i,
   // back-end read channel
   output logic       rd_req_o,
   output line_addr_t rd_addr_o,
   input  logic       rd_valid_i,
   input  offset_t    rd_beat_i,
   input  data_t      rd_data_i,
   input  logic       rd_busy_i,
   // back-end write channel
   output logic       wr_req_o,
   output word_addr_t wr_addr_o,
   output data_t      wr_data_o,
   output strb_t      wr_strb_o,
   input  logic       wr_ack_i,
   // status and counter strobes
   output logic       wtbuf_full_o,
   output logic       wtbuf_empty_o,
   output logic       write_hit_o,
   output logic       write_miss_o,
   output logic       read_hit_o,
   output logic       read_miss_o
);

   logic         req_q;
   word_addr_t   addr_q;
   data_t        wdata_q;
   strb_t        wstrb_q;
   index_t       index;
   index_t       index_q;
   tag_t         tag_q;
   offset_t      offset_q;
   way_t         way_hit;
   way_t         victim;
   logic         fill;
   logic         touch;
   logic         wr_en;
   logic         buf_push;
   wtbuf_entry_t push_entry;
   wtbuf_entry_t head_entry;

   ////////////////////
   // request stage
   ////////////////////

   // host still holds the request while ack is high
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         req_q <= 1'b0;
      end else begin
         req_q <= req_i & ~ack_o;
      end
   end

   always_ff @(posedge clk_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
   end

   // arrays read from the live index, compares use the registered fields
   assign index    = addr_i[WORD_OFFSET_W +: NLINES_W];
   assign index_q  = addr_q[WORD_OFFSET_W +: NLINES_W];
   assign tag_q    = addr_q[WORD_OFFSET_W + NLINES_W +: TAG_W];
   assign offset_q = addr_q[WORD_OFFSET_W-1:0];

   assign rd_addr_o = addr_q[$bits(word_addr_t)-1:WORD_OFFSET_W];

   assign touch = read_hit_o | write_hit_o;

   assign push_entry = '{addr: addr_q, data: wdata_q, strb: wstrb_q};
   assign wr_req_o   = ~wtbuf_empty_o;
   assign wr_addr_o  = head_entry.addr;
   assign wr_data_o  = head_entry.data;
   assign wr_strb_o  = head_entry.strb;

   cache_ctrl u_ctrl (
      .clk_i,
      .arst_i,
      .req_q_i      (req_q),
      .wstrb_q_i    (wstrb_q),
      .offset_q_i   (offset_q),
      .way_hit_i    (way_hit),
      .rd_busy_i    (rd_busy_i),
      .buf_full_i   (wtbuf_full_o),
      .buf_empty_i  (wtbuf_empty_o),
      .wr_ack_i     (wr_ack_i),
      .ack_o        (ack_o),
      .fill_o       (fill),
      .buf_push_o   (buf_push),
      .wr_en_o      (wr_en),
      .rd_req_o     (rd_req_o),
      .write_hit_o  (write_hit_o),
      .write_miss_o (write_miss_o),
      .read_hit_o   (read_hit_o),
      .read_miss_o  (read_miss_o)
   );

   cache_tag_array u_tag_array (
      .clk_i,
      .arst_i,
      .invalidate_i (invalidate_i),
      .index_i      (index),
      .index_q_i    (index_q),
      .tag_q_i      (tag_q),
      .fill_i       (fill),
      .touch_i      (touch),
      .way_hit_o    (way_hit),
      .victim_o     (victim)
   );

   cache_data_array u_data_array (
      .clk_i,
      .index_i      (index),
      .index_q_i    (index_q),
      .offset_q_i   (offset_q),
      .way_hit_i    (way_hit),
      .victim_i     (victim),
      .wr_en_i      (wr_en),
      .wstrb_q_i    (wstrb_q),
      .wdata_q_i    (wdata_q),
      .rd_busy_i    (rd_busy_i),
      .rd_valid_i   (rd_valid_i),
      .rd_beat_i    (rd_beat_i),
      .rd_data_i    (rd_data_i),
      .rdata_o      (rdata_o)
   );

   cache_wt_buffer u_wt_buffer (
      .clk_i,
      .arst_i,
      .push_i       (buf_push),
      .entry_i      (push_entry),
      .pop_i        (wr_ack_i),
      .entry_o      (head_entry),
      .empty_o      (wtbuf_empty_o),
      .full_o       (wtbuf_full_o)
   );

endmodule

/* verilog/cache_wt_buffer.sv */
module cache_wt_buffer
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic         clk_i,
   input  logic         arst_i,
   input  logic         push_i,
   input  wtbuf_entry_t entry_i,
   input  logic         pop_i,
   output wtbuf_entry_t entry_o,
   output logic         empty_o,
   output logic         full_o
);

   wtbuf_entry_t mem [WTBUF_DEPTH];

   // extra msb tells full from empty
   logic [WTBUF_DEPTH_W:0]   wr_ptr_q;
   logic [WTBUF_DEPTH_W:0]   rd_ptr_q;
   logic [WTBUF_DEPTH_W-1:0] wr_slot;
   logic [WTBUF_DEPTH_W-1:0] rd_slot;

   assign wr_slot = wr_ptr_q[WTBUF_DEPTH_W-1:0];
   assign rd_slot = rd_ptr_q[WTBUF_DEPTH_W-1:0];

   assign empty_o = (wr_ptr_q == rd_ptr_q);
   assign full_o  = (wr_slot == rd_slot) &
                    (wr_ptr_q[WTBUF_DEPTH_W] != rd_ptr_q[WTBUF_DEPTH_W]);

   // oldest entry always on the output
   assign entry_o = mem[rd_slot];

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem[wr_slot] <= entry_i;
      end
   end

   // a full buffer only takes a write while its head is accepted
   a_no_overflow: assert property (@(posedge clk_i) disable iff (arst_i)
      push_i && full_o |-> pop_i);

   // back end only accepts what it was offered
   a_no_underflow: assert property (@(posedge clk_i) disable iff (arst_i)
      pop_i |-> !empty_o);

endmodule
